/* verilog/twiddle_pkg.sv */
`default_nettype none

package twiddle_pkg;

    // ==============================
    // default sizes
    // ==============================

    // every table value below fits in one twiddle word
    localparam int word_width = 28;

    // butterfly lanes served by one access
    localparam int lane_count = 15;

    // iteration depths kept in the base table
    localparam int row_count = 5;

    // entries of the fixed constant table
    localparam int const_count = 14;

    localparam int row_width = $clog2(row_count);
    localparam int idx_width = $clog2(const_count);

    typedef logic [word_width-1:0] word_t;

    // ==============================
    // reset contents
    // ==============================

    // base twiddles hold one row per iteration depth with lane 0 first
    localparam word_t base_init [row_count][lane_count] = '{
        '{
            28'h3e3a2b0, 28'h442e7e8, 28'h1cff90a, 28'h6f76bcb,
            28'h19bf5d5, 28'h7dbe285, 28'h2646f0b, 28'h108822e,
            28'h09dbc38, 28'h698c44d, 28'h7f5e353, 28'h3d22f79,
            28'h259c593, 28'h0e25dd5, 28'h9884296
        },
        '{
            28'h339af8f, 28'h005a761, 28'h1cf41c6, 28'h1905fdb,
            28'h17fc5dd, 28'h120de63, 28'h9ac3146, 28'h372a390,
            28'h7aa4c57, 28'h1230ae7, 28'h6617b95, 28'h7cdff82,
            28'h68cdd99, 28'h86e7108, 28'h4454f67
        },
        '{
            28'h808a836, 28'h4fc14e6, 28'h4899ee9, 28'h8fcf14c,
            28'h17d1a3e, 28'h2b9bdb3, 28'h367537e, 28'h280df35,
            28'h1debef5, 28'h6cc01f1, 28'h68a1e5c, 28'h7e0af96,
            28'h4874eb9, 28'h760187e, 28'h66c411f
        },
        '{
            28'h33fe7d2, 28'h0122a49, 28'h8f3339a, 28'h66fc73b,
            28'h4bc73ea, 28'h88a9d60, 28'h9b086e1, 28'h44f23cb,
            28'h963090d, 28'h78486cd, 28'h044ea3e, 28'h093bab2,
            28'h55189ed, 28'h6fcdb71, 28'h62fa6b8
        },
        // last depth only needs a single root in lane 0
        '{
            28'h7b37359, 28'h0000000, 28'h0000000, 28'h0000000,
            28'h0000000, 28'h0000000, 28'h0000000, 28'h0000000,
            28'h0000000, 28'h0000000, 28'h0000000, 28'h0000000,
            28'h0000000, 28'h0000000, 28'h0000000
        }
    };

    // entry 13 of the constant twiddles is the unit root
    localparam word_t const_init [const_count] = '{
        28'h7b37359, 28'h280df35, 28'h8fcf14c, 28'h4fc14e6,
        28'h808a836, 28'h372a390, 28'h1905fdb, 28'h005a761,
        28'h339af8f, 28'h108822e, 28'h6f76bcb, 28'h442e7e8,
        28'h3e3a2b0, 28'h0000001
    };

endpackage

`default_nettype wire

/* verilog/tf_base_bank.sv */
`default_nettype none

module tf_base_bank #(
    parameter int data_width = twiddle_pkg::word_width,
    parameter int lanes      = twiddle_pkg::lane_count,
    parameter int rows       = twiddle_pkg::row_count
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rd_en,
    input  logic                              wr_en,
    input  logic [twiddle_pkg::row_width-1:0] rd_row,
    input  logic [twiddle_pkg::row_width-1:0] wr_row,
    input  logic [lanes*data_width-1:0]       wr_data,
    output logic [lanes*data_width-1:0]       base_out
);

    import twiddle_pkg::*;

    // one word per lane for each iteration depth
    logic [data_width-1:0] base_mem [rows][lanes];

    // ==============================
    // row store
    // ==============================

    // the whole row is replaced at once and there are no partial lane writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < rows; r++) begin
                for (int k = 0; k < lanes; k++) begin
                    base_mem[r][k] <= data_width'(base_init[r][k]);
                end
            end
        end else if (wr_en) begin
            for (int k = 0; k < lanes; k++) begin
                base_mem[wr_row][k] <= wr_data[k*data_width +: data_width];
            end
        end
    end

    // ==============================
    // registered row read
    // ==============================

    // a read and a write to the same row in one cycle returns the old row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_out <= '0;
        end else if (rd_en) begin
            for (int k = 0; k < lanes; k++) begin
                base_out[k*data_width +: data_width] <= base_mem[rd_row][k];
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    // reset contents only exist for the default table size and below
    a_table_fit: assert property (
        @(posedge clk) (rows <= row_count) && (lanes <= lane_count)
    ) else $error("base bank sized beyond base_init");

    a_rd_row_range: assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> (rd_row < rows)
    ) else $error("rd_row %0d outside base table", rd_row);

    a_wr_row_range: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_row < rows)
    ) else $error("wr_row %0d outside base table", wr_row);

endmodule

`default_nettype wire

/* verilog/tf_const_table.sv */
`default_nettype none

module tf_const_table #(
    parameter int data_width = twiddle_pkg::word_width,
    parameter int lanes      = twiddle_pkg::lane_count,
    parameter int entries    = twiddle_pkg::const_count
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    rd_en,
    input  logic [lanes*twiddle_pkg::idx_width-1:0] const_idx,
    output logic [lanes*data_width-1:0]             const_out
);

    import twiddle_pkg::*;

    // ==============================
    // per lane lookup
    // ==============================

    // every lane has its own index and several lanes may pick the same entry
    // the table is never written and lanes read const_init directly
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            const_out <= '0;
        end else if (rd_en) begin
            for (int k = 0; k < lanes; k++) begin
                const_out[k*data_width +: data_width] <=
                    data_width'(const_init[const_idx[k*idx_width +: idx_width]]);
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    a_table_fit: assert property (
        @(posedge clk) entries <= const_count
    ) else $error("constant table sized beyond const_init");

    for (genvar k = 0; k < lanes; k++) begin : g_idx_check
        a_idx_range: assert property (
            @(posedge clk) disable iff (rst)
            rd_en |-> (const_idx[k*idx_width +: idx_width] < entries)
        ) else $error("lane %0d index outside constant table", k);
    end

endmodule

`default_nettype wire

/* verilog/twiddle_regfile.sv */
`default_nettype none

module twiddle_regfile #(
    parameter int data_width = twiddle_pkg::word_width,
    parameter int lanes      = twiddle_pkg::lane_count,
    parameter int rows       = twiddle_pkg::row_count,
    parameter int entries    = twiddle_pkg::const_count
) (
    input  logic                                    clk,
    input  logic                                    rst,

    // strobes shared by both stores
    input  logic                                    rd_en,
    input  logic                                    wr_en,

    // base table access
    input  logic [twiddle_pkg::row_width-1:0]       rd_row,
    input  logic [twiddle_pkg::row_width-1:0]       wr_row,
    input  logic [lanes*data_width-1:0]             wr_data,

    // one constant index per lane
    input  logic [lanes*twiddle_pkg::idx_width-1:0] const_idx,

    // both reads land on the same edge
    output logic [lanes*data_width-1:0]             base_out,
    output logic [lanes*data_width-1:0]             const_out
);

    // ==============================
    // rewritable base rows
    // ==============================

    tf_base_bank #(
        .data_width (data_width),
        .lanes      (lanes),
        .rows       (rows)
    ) u_base_bank (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .wr_en    (wr_en),
        .rd_row   (rd_row),
        .wr_row   (wr_row),
        .wr_data  (wr_data),
        .base_out (base_out)
    );

    // ==============================
    // fixed constants
    // ==============================

    // writes only target the base rows, so this side never sees wr_en
    tf_const_table #(
        .data_width (data_width),
        .lanes      (lanes),
        .entries    (entries)
    ) u_const_table (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .const_idx (const_idx),
        .const_out (const_out)
    );

endmodule

`default_nettype wire

/* verification/twiddle_model.svh */
`ifndef TWIDDLE_MODEL_SVH
`define TWIDDLE_MODEL_SVH

// expected contents of both tables follow the DUT edge by edge
word_t model_base [row_count][lane_count];
word_t model_const [const_count];

// expected registered outputs
logic [lane_count*word_width-1:0] exp_base;
logic [lane_count*word_width-1:0] exp_const;

task automatic reset_model();
    for (int r = 0; r < row_count; r++) begin
        for (int k = 0; k < lane_count; k++) begin
            model_base[r][k] = base_init[r][k];
        end
    end
    for (int e = 0; e < const_count; e++) begin
        model_const[e] = const_init[e];
    end
    exp_base = '0;
    exp_const = '0;
endtask

// on each rising edge the read sees the table as it was before that edge's write
task automatic apply_edge(
    input logic                             rd,
    input logic                             wr,
    input logic [row_width-1:0]             rrow,
    input logic [row_width-1:0]             wrow,
    input logic [lane_count*word_width-1:0] wdata,
    input logic [lane_count*idx_width-1:0]  idx
);
    int e;
    if (rd) begin
        for (int k = 0; k < lane_count; k++) begin
            exp_base[k*word_width +: word_width] = model_base[rrow][k];
            e = idx[k*idx_width +: idx_width];
            exp_const[k*word_width +: word_width] = model_const[e];
        end
    end
    if (wr) begin
        for (int k = 0; k < lane_count; k++) begin
            model_base[wrow][k] = wdata[k*word_width +: word_width];
        end
    end
endtask

`endif

/* verification/twiddle_regfile_tb.sv */
`default_nettype none

module twiddle_regfile_tb;

    import twiddle_pkg::*;

    localparam int reset_cycles = 8;
    localparam int step_count = 24;
    localparam int timeout_time = (step_count + reset_cycles + 4) * 20 + 400;

    // index modes for the constant lookups
    localparam logic [1:0] idx_seq  = 2'd0;
    localparam logic [1:0] idx_same = 2'd1;
    localparam logic [1:0] idx_rand = 2'd2;

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [row_width-1:0] rrow;
        logic [row_width-1:0] wrow;
        logic                 rnd_data;
        logic [1:0]           idx_mode;
    } step_t;

    // rd, wr, rd_row, wr_row, random data, index mode
    localparam step_t steps [step_count] = '{
        // every base row straight after reset
        '{1'b1, 1'b0, 3'd0, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd1, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd2, 3'd0, 1'b0, idx_same},
        '{1'b1, 1'b0, 3'd3, 3'd0, 1'b0, idx_rand},
        '{1'b1, 1'b0, 3'd4, 3'd0, 1'b0, idx_seq},
        // constant lookups with lanes sharing entries
        '{1'b1, 1'b0, 3'd0, 3'd0, 1'b0, idx_same},
        '{1'b1, 1'b0, 3'd1, 3'd0, 1'b0, idx_rand},
        '{1'b1, 1'b0, 3'd2, 3'd0, 1'b0, idx_rand},
        // write a row, read it back and look at its neighbours
        '{1'b0, 1'b1, 3'd0, 3'd2, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd2, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd1, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd3, 3'd0, 1'b0, idx_rand},
        // read and write of the same row in one cycle
        '{1'b1, 1'b1, 3'd3, 3'd3, 1'b1, idx_rand},
        '{1'b1, 1'b0, 3'd3, 3'd0, 1'b0, idx_same},
        '{1'b1, 1'b1, 3'd4, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd0, 3'd0, 1'b0, idx_seq},
        // idle cycles where one of them writes
        '{1'b0, 1'b0, 3'd1, 3'd0, 1'b0, idx_rand},
        '{1'b0, 1'b1, 3'd2, 3'd4, 1'b1, idx_rand},
        '{1'b0, 1'b0, 3'd3, 3'd1, 1'b0, idx_same},
        '{1'b1, 1'b0, 3'd4, 3'd0, 1'b0, idx_rand},
        '{1'b1, 1'b0, 3'd2, 3'd0, 1'b0, idx_seq},
        '{1'b1, 1'b1, 3'd4, 3'd4, 1'b0, idx_seq},
        '{1'b1, 1'b0, 3'd4, 3'd0, 1'b0, idx_seq},
        '{1'b0, 1'b0, 3'd0, 3'd0, 1'b0, idx_seq}
    };

    logic                             clk;
    logic                             rst;
    logic                             rd_en;
    logic                             wr_en;
    logic [row_width-1:0]             rd_row;
    logic [row_width-1:0]             wr_row;
    logic [lane_count*word_width-1:0] wr_data;
    logic [lane_count*idx_width-1:0]  const_idx;
    logic [lane_count*word_width-1:0] base_out;
    logic [lane_count*word_width-1:0] const_out;

    integer seed;
    int     errors;
    int     checks;

    `include "twiddle_model.svh"

    twiddle_regfile #(
        .data_width (word_width),
        .lanes      (lane_count),
        .rows       (row_count),
        .entries    (const_count)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .rd_row    (rd_row),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .const_idx (const_idx),
        .base_out  (base_out),
        .const_out (const_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // ==============================
    // stimulus helpers
    // ==============================

    task automatic fill_data(input int step, input logic rnd);
        for (int k = 0; k < lane_count; k++) begin
            if (rnd) begin
                wr_data[k*word_width +: word_width] = word_t'($random(seed));
            end else begin
                wr_data[k*word_width +: word_width] =
                    word_t'(32'h0a00000 + (step << 12) + k * 32'h111);
            end
        end
    endtask

    task automatic fill_indices(input int step, input logic [1:0] mode);
        int e;
        for (int k = 0; k < lane_count; k++) begin
            case (mode)
                idx_same: e = step % const_count;
                idx_rand: e = $unsigned($random(seed)) % const_count;
                default:  e = (step + k) % const_count;
            endcase
            const_idx[k*idx_width +: idx_width] = idx_width'(e);
        end
    endtask

    task automatic drive_step(input int i);
        rd_en = steps[i].rd;
        wr_en = steps[i].wr;
        rd_row = steps[i].rrow;
        wr_row = steps[i].wrow;
        fill_data(i, steps[i].rnd_data);
        fill_indices(i, steps[i].idx_mode);
    endtask

    task automatic compare_outputs();
        word_t got;
        word_t exp;
        checks++;
        for (int k = 0; k < lane_count; k++) begin
            got = base_out[k*word_width +: word_width];
            exp = exp_base[k*word_width +: word_width];
            if (got !== exp) begin
                $display("MISMATCH time=%0t base_out lane %0d expected %h got %h",
                         $time, k, exp, got);
                errors++;
            end
            got = const_out[k*word_width +: word_width];
            exp = exp_const[k*word_width +: word_width];
            if (got !== exp) begin
                $display("MISMATCH time=%0t const_out lane %0d expected %h got %h",
                         $time, k, exp, got);
                errors++;
            end
        end
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        seed = 32'head3;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        rd_en = 1'b0;
        wr_en = 1'b0;
        rd_row = '0;
        wr_row = '0;
        wr_data = '0;
        const_idx = '0;
        reset_model();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_outputs();

        for (int i = 0; i < step_count; i++) begin
            drive_step(i);
            @(posedge clk);
            apply_edge(rd_en, wr_en, rd_row, wr_row, wr_data, const_idx);
            @(negedge clk);
            compare_outputs();
        end
        rd_en = 1'b0;
        wr_en = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(timeout_time);
        $display("watchdog expired at %0t before the stimulus table finished", $time);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
verilog/twiddle_pkg.sv
verilog/tf_base_bank.sv
verilog/tf_const_table.sv
verilog/twiddle_regfile.sv
verification/twiddle_regfile_tb.sv

/* Makefile */
# Verilator build and run for the twiddle register file

VERILATOR   ?= verilator
TOP         ?= twiddle_regfile_tb
FILELIST    ?= sim.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= -j 0
PASS_TEXT   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
